//--- Bender.yml
package:
  name: cache_subsystem

sources:
  - common/cachePkg.sv
  - hw/Fifo.sv
  - hw/CacheDataArray.sv
  - hw/CacheArbiter.sv
  - cacheIf/CacheLineWriter.sv
  - cacheIf/CacheReadInterface.sv
  - hw/CacheSubsystem.sv
  - target: test
    files:
      - test/cacheSubsystem_properties.sv
      - test/CacheSubsystemTb.sv

//--- cacheIf/CacheLineWriter.sv
`timescale 1ns/10ps

module CacheLineWriter import cachePkg::*; #(
    parameter int queueDepth = 2
) (
    input logic clk,
    input logic rst,
    input logic wrStrobe,
    input WriteReq wrReq,
    output logic wrBusy,
    input logic grant,
    output ArrayCmd arrayCmd
);
    logic [$clog2(queueDepth):0] queueFree;
    logic pushOk;
    logic lineValid;
    WriteReq line;
    logic [lineOffBits-1:0] wordIdx;
    logic lastWord;

    // A strobe into a full queue is lost
    assign pushOk = wrStrobe && (queueFree != '0);

    Fifo #(.payloadT(WriteReq), .depth(queueDepth)) fillQueue (
        .clk(clk),
        .rst(rst),
        .pushValid(pushOk),
        .pushData(wrReq),
        .popValid(lineValid),
        .popReady(lastWord),
        .popData(line),
        .free(queueFree)
    );

    // Head line stays queued until its final word is written
    assign lastWord = lineValid && grant && (wordIdx == lineOffBits'(lineWords - 1));
    assign wrBusy = lineValid;

    always_ff @(posedge clk) begin
        if (rst) begin
            wordIdx <= '0;
        end else if (lineValid && grant) begin
            wordIdx <= wordIdx + 1'b1;
        end
    end

    always_comb begin
        arrayCmd.ce = !lineValid;
        arrayCmd.we = !lineValid;
        arrayCmd.addr = {line.lineAddr, wordIdx};
        arrayCmd.wdata = line.data[wordIdx*cWidth +: cWidth];
    end

endmodule

//--- cacheIf/CacheReadInterface.sv
`timescale 1ns/10ps

module CacheReadInterface import cachePkg::*; #(
    parameter int bufLen = 4
) (
    input logic clk,
    input logic rst,
    input ReadReq req,
    output logic reqReady,
    output logic beatValid,
    input logic beatReady,
    output ReadBeat beat,
    input logic grant,
    output ArrayCmd arrayCmd,
    input logic [cWidth-1:0] rdata
);
    localparam int idxBits = $clog2(wordsPerBeat);
    localparam int lastIdx = wordsPerBeat - 1;
    localparam int cntBits = $clog2((bufLen + 1) * wordsPerBeat) + 1;

    typedef struct packed {
        ReadReq req;
        logic [lenBits-1:0] progress;
    } Transfer;

    typedef struct packed {
        logic valid;
        logic [idBits-1:0] id;
        logic last;
        logic mmio;
        logic [cWidth-1:0] mmioData;
    } ReadMeta;

    Transfer cur;
    Transfer next;
    Transfer incoming;
    ReadMeta readMeta;
    ReadMeta [1:0] metaPipe;

    logic [$clog2(bufLen):0] fifoFree;
    logic pushValid;
    ReadBeat pushBeat;

    logic [lastIdx*cWidth-1:0] acc;
    logic [idxBits-1:0] accIdx;
    logic [cntBits-1:0] inFlight;
    logic [cntBits-1:0] freeWords;
    logic allowNewRead;
    logic [lineOffBits-1:0] wordOff;
    logic readSucc;
    logic reqFire;

    Fifo #(.payloadT(ReadBeat), .depth(bufLen)) beatFifo (
        .clk(clk),
        .rst(rst),
        .pushValid(pushValid),
        .pushData(pushBeat),
        .popValid(beatValid),
        .popReady(beatReady),
        .popData(beat),
        .free(fifoFree)
    );

    ///////////////////////////////
    // Issue
    ///////////////////////////////

    // An MMIO entry will fill a whole beat slot
    function automatic logic [cntBits-1:0] pipeWords(ReadMeta m);
        if (!m.valid) return '0;
        return m.mmio ? cntBits'(wordsPerBeat) : cntBits'(1);
    endfunction

    always_comb begin
        inFlight = cntBits'(accIdx) + pipeWords(metaPipe[0]) + pipeWords(metaPipe[1]);
        freeWords = cntBits'(fifoFree) * cntBits'(wordsPerBeat);
        allowNewRead = freeWords > inFlight;
    end

    always_comb begin
        wordOff = cur.req.addr[lineOffBits-1:0] + cur.progress[lineOffBits-1:0];
        readMeta = '0;
        arrayCmd = '0;
        arrayCmd.ce = 1'b1;
        arrayCmd.we = 1'b1;
        // Wrap inside the line
        arrayCmd.addr = {cur.req.addr[addrBits-1:lineOffBits], wordOff};
        if (cur.req.valid && allowNewRead) begin
            readMeta.valid = 1'b1;
            readMeta.id = cur.req.id;
            readMeta.last = cur.req.mmio || (cur.progress == cur.req.len);
            readMeta.mmio = cur.req.mmio;
            readMeta.mmioData = cur.req.mmioData;
            arrayCmd.ce = cur.req.mmio;
        end
    end

    assign readSucc = readMeta.valid && (grant || readMeta.mmio);
    assign reqReady = !next.req.valid || (readSucc && readMeta.last);
    assign reqFire = req.valid && reqReady;
    assign incoming = '{req: req, progress: '0};

    always_ff @(posedge clk) begin
        if (rst) begin
            cur <= '0;
            next <= '0;
            metaPipe <= '0;
        end else begin
            metaPipe <= {metaPipe[0], readSucc ? readMeta : ReadMeta'('0)};
            if (readSucc && readMeta.last) begin
                if (next.req.valid) begin
                    cur <= next;
                    next <= reqFire ? incoming : Transfer'('0);
                end else begin
                    cur <= reqFire ? incoming : Transfer'('0);
                end
            end else begin
                if (readSucc) cur.progress <= cur.progress + 1'b1;
                if (reqFire) begin
                    if (!cur.req.valid) cur <= incoming;
                    else next <= incoming;
                end
            end
        end
    end

    ///////////////////////////////
    // Beat assembly
    ///////////////////////////////

    always_comb begin
        pushValid = 1'b0;
        pushBeat = '0;
        pushBeat.id = metaPipe[1].id;
        pushBeat.last = metaPipe[1].last;
        if (metaPipe[1].valid) begin
            if (metaPipe[1].mmio) begin
                pushValid = 1'b1;
                pushBeat.data = iWidth'(metaPipe[1].mmioData);
            end else if (accIdx == idxBits'(lastIdx)) begin
                pushValid = 1'b1;
                pushBeat.data = {rdata, acc};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            accIdx <= '0;
        end else if (metaPipe[1].valid && !metaPipe[1].mmio) begin
            accIdx <= (accIdx == idxBits'(lastIdx)) ? '0 : accIdx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (metaPipe[1].valid && !metaPipe[1].mmio && accIdx != idxBits'(lastIdx)) begin
            acc[accIdx*cWidth +: cWidth] <= rdata;
        end
    end

endmodule

//--- common/cachePkg.sv
package cachePkg;

    ///////////////////////////////
    // Geometry
    ///////////////////////////////

    localparam int addrBits = 10;
    localparam int lenBits = 8;
    localparam int cWidth = 32;
    localparam int iWidth = 128;
    localparam int idBits = 2;

    localparam int wordsPerBeat = iWidth / cWidth;
    localparam int lineWords = 16;
    localparam int lineOffBits = $clog2(lineWords);
    localparam int lineAddrBits = addrBits - lineOffBits;
    localparam int lineBits = lineWords * cWidth;

    ///////////////////////////////
    // Bundles
    ///////////////////////////////

    // len is the index of the last word, inclusive
    typedef struct packed {
        logic valid;
        logic [idBits-1:0] id;
        logic [lenBits-1:0] len;
        logic [addrBits-1:0] addr;
        logic mmio;
        logic [cWidth-1:0] mmioData;
    } ReadReq;

    typedef struct packed {
        logic [iWidth-1:0] data;
        logic [idBits-1:0] id;
        logic last;
    } ReadBeat;

    typedef struct packed {
        logic [lineAddrBits-1:0] lineAddr;
        logic [lineBits-1:0] data;
    } WriteReq;

    // ce and we are active low
    typedef struct packed {
        logic ce;
        logic we;
        logic [addrBits-1:0] addr;
        logic [cWidth-1:0] wdata;
    } ArrayCmd;

endpackage

//--- filelist.f
common/cachePkg.sv
hw/Fifo.sv
hw/CacheDataArray.sv
hw/CacheArbiter.sv
cacheIf/CacheLineWriter.sv
cacheIf/CacheReadInterface.sv
hw/CacheSubsystem.sv
test/cacheSubsystem_properties.sv
test/CacheSubsystemTb.sv

//--- hw/CacheArbiter.sv
`timescale 1ns/10ps

module CacheArbiter import cachePkg::*; (
    input logic clk,
    input logic rst,
    input ArrayCmd rdCmd,
    input ArrayCmd wrCmd,
    output logic rdGrant,
    output logic wrGrant,
    output ArrayCmd cmd
);
    localparam int lossBits = $clog2(lineWords) + 2;

    // Consecutive cycles the reader asked and lost
    logic [lossBits-1:0] rdLossCount;

    // Writer always wins
    assign wrGrant = !wrCmd.ce;
    assign rdGrant = wrCmd.ce;

    always_comb begin
        if (!wrCmd.ce) begin
            cmd = wrCmd;
        end else if (!rdCmd.ce) begin
            cmd = rdCmd;
        end else begin
            cmd = '0;
            cmd.ce = 1'b1;
            cmd.we = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdLossCount <= '0;
        end else if (!rdCmd.ce && !wrCmd.ce) begin
            if (rdLossCount != '1) rdLossCount <= rdLossCount + 1'b1;
        end else begin
            rdLossCount <= '0;
        end
    end

endmodule

//--- hw/CacheDataArray.sv
`timescale 1ns/10ps

module CacheDataArray import cachePkg::*; (
    input logic clk,
    input logic rst,
    input ArrayCmd cmd,
    output logic [cWidth-1:0] rdata
);
    localparam int numWords = 1 << addrBits;

    logic [cWidth-1:0] mem [numWords];
    logic [cWidth-1:0] readStage;

    always_ff @(posedge clk) begin
        if (!cmd.ce) begin
            if (!cmd.we) mem[cmd.addr] <= cmd.wdata;
            else readStage <= mem[cmd.addr];
        end
    end

    // Second stage gives the fixed two-cycle read latency
    always_ff @(posedge clk) begin
        if (rst) rdata <= '0;
        else rdata <= readStage;
    end

endmodule

//--- hw/CacheSubsystem.sv
`timescale 1ns/10ps

module CacheSubsystem import cachePkg::*; #(
    parameter int bufLen = 4,
    parameter int queueDepth = 2
) (
    input logic clk,
    input logic rst,
    input ReadReq req,
    output logic reqReady,
    output logic beatValid,
    input logic beatReady,
    output ReadBeat beat,
    input logic wrStrobe,
    input WriteReq wrReq,
    output logic wrBusy
);
    ArrayCmd rdCmd;
    ArrayCmd wrCmd;
    ArrayCmd arrayCmd;
    logic rdGrant;
    logic wrGrant;
    logic [cWidth-1:0] rdata;

    CacheReadInterface #(.bufLen(bufLen)) readIf (
        .clk(clk),
        .rst(rst),
        .req(req),
        .reqReady(reqReady),
        .beatValid(beatValid),
        .beatReady(beatReady),
        .beat(beat),
        .grant(rdGrant),
        .arrayCmd(rdCmd),
        .rdata(rdata)
    );

    CacheLineWriter #(.queueDepth(queueDepth)) writer (
        .clk(clk),
        .rst(rst),
        .wrStrobe(wrStrobe),
        .wrReq(wrReq),
        .wrBusy(wrBusy),
        .grant(wrGrant),
        .arrayCmd(wrCmd)
    );

    CacheArbiter arbiter (
        .clk(clk),
        .rst(rst),
        .rdCmd(rdCmd),
        .wrCmd(wrCmd),
        .rdGrant(rdGrant),
        .wrGrant(wrGrant),
        .cmd(arrayCmd)
    );

    CacheDataArray dataArray (
        .clk(clk),
        .rst(rst),
        .cmd(arrayCmd),
        .rdata(rdata)
    );

endmodule

//--- hw/Fifo.sv
`timescale 1ns/10ps

module Fifo #(
    parameter type payloadT = logic,
    parameter int depth = 4
) (
    input logic clk,
    input logic rst,
    input logic pushValid,
    input payloadT pushData,
    output logic popValid,
    input logic popReady,
    output payloadT popData,
    output logic [$clog2(depth):0] free
);
    localparam int ptrBits = (depth > 1) ? $clog2(depth) : 1;
    localparam int freeBits = $clog2(depth) + 1;

    payloadT mem [depth];
    logic [ptrBits-1:0] rdPtr;
    logic [ptrBits-1:0] wrPtr;
    logic doPop;

    function automatic logic [ptrBits-1:0] bump(logic [ptrBits-1:0] ptr);
        return (ptr == ptrBits'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign popValid = (free != freeBits'(depth));
    assign popData = mem[rdPtr];
    assign doPop = popValid && popReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            free <= freeBits'(depth);
        end else begin
            if (pushValid) wrPtr <= bump(wrPtr);
            if (doPop) rdPtr <= bump(rdPtr);
            // Push and pop together leave the count alone
            if (pushValid && !doPop) free <= free - 1'b1;
            else if (doPop && !pushValid) free <= free + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pushValid) mem[wrPtr] <= pushData;
    end

endmodule

//--- test/CacheSubsystemTb.sv
`timescale 1ns/10ps

module CacheSubsystemTb import cachePkg::*; ();
    // Rough cycle budget per test: reset, fill, wrap, mmio, stall, contention
    localparam int testCycles = 8 + 4 + 100 + 50 + 40 + 120 + 110;
    localparam int timeoutCycles = testCycles * 2 + 200;

    logic clk;
    logic rst;
    ReadReq req;
    logic reqReady;
    logic beatValid;
    logic beatReady;
    ReadBeat beat;
    logic wrStrobe;
    WriteReq wrReq;
    logic wrBusy;

    logic [cWidth-1:0] model [1 << addrBits];
    ReadBeat expQ [$];
    string curTest = "none";
    logic stallOn = 1'b0;
    logic [63:0] stallPattern = '1;
    int cycleCount = 0;
    int errorCount = 0;
    int testErrors = 0;
    int testsRun = 0;

    CacheSubsystem #(.bufLen(4), .queueDepth(2)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout after %0d cycles, test %s did not complete", cycleCount, curTest);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Stream ready, optionally stalled
    always @(posedge clk) begin
        #2;
        beatReady = stallOn ? stallPattern[cycleCount % 64] : 1'b1;
    end

    //////////////////////////////
    // Checking
    //////////////////////////////

    task automatic noteError;
        errorCount++;
        testErrors++;
    endtask

    task automatic checkBeat(input ReadBeat exp, input ReadBeat act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected data=%h id=%0d last=%b, actual data=%h id=%0d last=%b",
                     curTest, exp.data, exp.id, exp.last, act.data, act.id, act.last);
            noteError();
        end
    endtask

    task automatic checkFlag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s: %s expected %b, actual %b", curTest, what, exp, act);
            noteError();
        end
    endtask

    // Beats transfer at the next rising edge, values are settled here
    always @(negedge clk) begin : beatMonitor
        ReadBeat expBeat;
        if (!rst && beatValid && beatReady) begin
            if (expQ.size() == 0) begin
                $display("Unexpected beat with id %0d in test %s", beat.id, curTest);
                noteError();
            end else begin
                expBeat = expQ.pop_front();
                checkBeat(expBeat, beat);
            end
        end
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    task automatic nextCycle;
        @(posedge clk);
        #2;
    endtask

    task automatic startTest(input string name);
        curTest = name;
        testErrors = 0;
    endtask

    task automatic endTest;
        testsRun++;
        $display("Test %-12s done, %0d errors", curTest, testErrors);
    endtask

    function automatic logic [addrBits-1:0] lineWord(input int line, input int off);
        return {lineAddrBits'(line), lineOffBits'(off)};
    endfunction

    task automatic fillLine(input int line);
        WriteReq w;
        logic [cWidth-1:0] word;
        w.lineAddr = lineAddrBits'(line);
        for (int k = 0; k < lineWords; k++) begin
            word = $urandom;
            w.data[k*cWidth +: cWidth] = word;
            model[lineWord(line, k)] = word;
        end
        wrReq = w;
        wrStrobe = 1'b1;
        nextCycle();
        wrStrobe = 1'b0;
    endtask

    task automatic waitFillDone;
        @(negedge clk);
        while (wrBusy) @(negedge clk);
        nextCycle();
    endtask

    // Word k sits at the line base plus (start + k) mod 16
    task automatic expectRead(input logic [addrBits-1:0] addr, input int len,
                              input logic [idBits-1:0] id);
        ReadBeat b;
        logic [addrBits-1:0] wordAddr;
        b = '0;
        for (int k = 0; k <= len; k++) begin
            wordAddr = {addr[addrBits-1:lineOffBits],
                        lineOffBits'((int'(addr[lineOffBits-1:0]) + k) % lineWords)};
            b.data[(k % wordsPerBeat)*cWidth +: cWidth] = model[wordAddr];
            if (k % wordsPerBeat == wordsPerBeat - 1) begin
                b.id = id;
                b.last = (k == len);
                expQ.push_back(b);
                b = '0;
            end
        end
    endtask

    task automatic sendRead(input ReadReq r);
        req = r;
        req.valid = 1'b1;
        @(negedge clk);
        while (!reqReady) @(negedge clk);
        nextCycle();
        req = '0;
    endtask

    task automatic readCache(input logic [addrBits-1:0] addr, input int len,
                             input logic [idBits-1:0] id);
        ReadReq r;
        r = '0;
        r.id = id;
        r.len = lenBits'(len);
        r.addr = addr;
        expectRead(addr, len, id);
        sendRead(r);
    endtask

    task automatic readMmio(input logic [cWidth-1:0] data, input logic [idBits-1:0] id);
        ReadReq r;
        ReadBeat b;
        r = '0;
        r.id = id;
        r.mmio = 1'b1;
        r.mmioData = data;
        b = '0;
        b.data[cWidth-1:0] = data;
        b.id = id;
        b.last = 1'b1;
        expQ.push_back(b);
        sendRead(r);
    endtask

    task automatic waitBeats;
        while (expQ.size() != 0) @(posedge clk);
        // Idle window catches extra beats
        repeat (8) @(posedge clk);
        #2;
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic testReset;
        startTest("reset");
        @(negedge clk);
        checkFlag("beatValid", 1'b0, beatValid);
        checkFlag("reqReady", 1'b1, reqReady);
        checkFlag("wrBusy", 1'b0, wrBusy);
        nextCycle();
        endTest();
    endtask

    task automatic testFillRead;
        startTest("fillRead");
        fillLine(3);
        fillLine(9);
        checkFlag("wrBusy", 1'b1, wrBusy);
        // Two queued lines keep the writer busy for 32 word cycles
        repeat (2 * lineWords - 2) nextCycle();
        checkFlag("wrBusy", 1'b1, wrBusy);
        nextCycle();
        checkFlag("wrBusy", 1'b0, wrBusy);
        readCache(lineWord(3, 0), 15, 0);
        readCache(lineWord(9, 0), 15, 1);
        waitBeats();
        endTest();
    endtask

    task automatic testWrap;
        startTest("wrap");
        readCache(lineWord(3, 8), 7, 1);
        readCache(lineWord(3, 12), 7, 2);
        waitBeats();
        endTest();
    endtask

    task automatic testMmio;
        startTest("mmio");
        for (int id = 0; id < 4; id++) begin
            readMmio($urandom, idBits'(id));
        end
        waitBeats();
        endTest();
    endtask

    task automatic testStall;
        startTest("stall");
        stallPattern = {$urandom, $urandom};
        stallOn = 1'b1;
        readCache(lineWord(9, 4), 7, 1);
        readMmio($urandom, 2);
        readCache(lineWord(3, 0), 15, 3);
        waitBeats();
        stallOn = 1'b0;
        endTest();
    endtask

    task automatic testContention;
        startTest("contention");
        readCache(lineWord(9, 0), 15, 0);
        fillLine(5);
        waitBeats();
        waitFillDone();
        readCache(lineWord(5, 6), 15, 1);
        waitBeats();
        endTest();
    endtask

    initial begin
        void'($urandom(32'h2553_afc0));
        rst = 1'b1;
        req = '0;
        beatReady = 1'b1;
        wrStrobe = 1'b0;
        wrReq = '0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        testReset();
        testFillRead();
        testWrap();
        testMmio();
        testStall();
        testContention();

        errorCount += dut.props.assertFails;
        $display("Summary: %0d tests, %0d errors, %0d assertion failures",
                 testsRun, errorCount, dut.props.assertFails);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- test/cacheSubsystem_properties.sv
`timescale 1ns/10ps

module cacheSubsystem_properties import cachePkg::*; #(
    parameter int queueDepth = 2
) (
    input logic clk,
    input logic rst,
    input logic beatValid,
    input logic beatReady,
    input ReadBeat beat,
    input logic wrStrobe,
    input logic [$clog2(queueDepth):0] queueFree,
    input logic rdGrant,
    input logic wrGrant,
    input ArrayCmd rdCmd,
    input ArrayCmd wrCmd,
    input ArrayCmd arrayCmd,
    input logic [$clog2(lineWords)+1:0] rdLossCount
);
    int assertFails = 0;

    beatHeld: assert property (@(posedge clk) disable iff (rst)
        beatValid && !beatReady |=> beatValid && $stable(beat))
        else begin
            assertFails++;
            $error("beat changed or dropped while the stream was stalled");
        end

    fillNoOverflow: assert property (@(posedge clk) disable iff (rst)
        wrStrobe |-> queueFree != '0)
        else begin
            assertFails++;
            $error("fill strobe arrived while the fill queue was full");
        end

    // An enabled array command belongs to exactly the one granted peer
    singleGrant: assert property (@(posedge clk) disable iff (rst)
        !arrayCmd.ce |-> (wrGrant ? (!rdGrant && arrayCmd == wrCmd)
                                  : (rdGrant && arrayCmd == rdCmd)))
        else begin
            assertFails++;
            $error("array command does not match the single granted peer");
        end

    // Reader waits at most one queued fill per slot
    boundedLoss: assert property (@(posedge clk) disable iff (rst)
        rdLossCount <= lineWords * queueDepth)
        else begin
            assertFails++;
            $error("reader starved longer than the queued fills allow");
        end

endmodule

bind CacheSubsystem cacheSubsystem_properties #(.queueDepth(queueDepth)) props (
    .clk(clk),
    .rst(rst),
    .beatValid(beatValid),
    .beatReady(beatReady),
    .beat(beat),
    .wrStrobe(wrStrobe),
    .queueFree(writer.queueFree),
    .rdGrant(rdGrant),
    .wrGrant(wrGrant),
    .rdCmd(rdCmd),
    .wrCmd(wrCmd),
    .arrayCmd(arrayCmd),
    .rdLossCount(arbiter.rdLossCount)
);
